/* all.f */
+incdir+src
src/axi_bus_pkg.sv
src/dma_cmd_pkg.sv
src/cmd_queue.sv
src/dma_rd_burst_gen.sv
src/dma_rd_align.sv
src/axis_skid_reg.sv
src/axi_dma_rd.sv
bench/tb_axi_dma_rd.sv

/* Makefile */
# Verilator flow for the read DMA testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_dma_rd
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST) \
		> $(LOG) 2>&1 || (cat $(LOG); exit 1)
	-./$(BUILD_DIR)/V$(TOP) >> $(LOG) 2>&1
	@tail -n 5 $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_axi_dma_rd.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_settings.svh"

module tb_axi_dma_rd;

    localparam int BPB = axi_bus_pkg::BYTES_PER_BEAT;
    localparam int NUM_DESC = 14;
    // descriptors before this index run with every ready held high
    localparam int STALL_FROM = 9;
    localparam int ADDR_LIST [NUM_DESC] = '{
        'h0100, 'h0200, 'h0300, 'h0400, 'h0501, 'h0602, 'h0703, 'h0FE5, 'h1FF8,
        'h2001, 'h2100, 'h2FFE, 'h3003, 'h3100
    };
    localparam int LEN_LIST [NUM_DESC] = '{
        64, 13, 4, 1, 7, 33, 5, 300, 400,
        50, 37, 90, 3, 128
    };

    logic aclk = 1'b0;
    logic aresetn = 1'b0;
    axi_bus_pkg::addr_t desc_addr = '0;
    axi_bus_pkg::len_t desc_len = '0;
    logic desc_valid = 1'b0;
    logic desc_ready;
    axi_bus_pkg::addr_t araddr;
    axi_bus_pkg::arlen_t arlen;
    logic arvalid;
    logic arready = 1'b0;
    axi_bus_pkg::data_t rdata = '0;
    logic rvalid = 1'b0;
    logic rready;
    axi_bus_pkg::data_t tdata;
    axi_bus_pkg::keep_t tkeep;
    logic tlast;
    logic tvalid;
    logic tready = 1'b0;
    logic status_valid;

    logic stall_en = 1'b0;
    logic [15:0] lfsr;
    int cycles = 0;
    int cycle_limit = 2000;
    int out_errors = 0;
    int ar_errors = 0;
    int accepted = 0;
    int beats = 0;
    int last_count = 0;
    int status_count = 0;
    int done_bytes = 0;
    int r_beat = 0;
    logic [7:0] exp_q[$];
    int len_q[$];
    int mem_addr_q[$];
    int mem_len_q[$];
    int ar_start_q[$];
    int ar_end_q[$];
    logic hold;
    axi_bus_pkg::data_t hold_data;
    axi_bus_pkg::keep_t hold_keep;
    logic hold_last;
    logic acc_d;
    logic ar_wait;
    axi_bus_pkg::addr_t ar_addr_d;
    axi_bus_pkg::arlen_t ar_len_d;

    axi_dma_rd dut0 (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .desc_addr    (desc_addr),
        .desc_len     (desc_len),
        .desc_valid   (desc_valid),
        .desc_ready   (desc_ready),
        .araddr       (araddr),
        .arlen        (arlen),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rvalid       (rvalid),
        .rready       (rready),
        .tdata        (tdata),
        .tkeep        (tkeep),
        .tlast        (tlast),
        .tvalid       (tvalid),
        .tready       (tready),
        .status_valid (status_valid)
    );

    always #4 aclk = ~aclk;

    // memory content, byte a holds the low byte of a*7+3
    function automatic logic [7:0] pattern(input int a);
        return 8'((a * 7) + 3);
    endfunction

    function automatic axi_bus_pkg::data_t beat_at(input int a);
        axi_bus_pkg::data_t d;
        for (int i = 0; i < BPB; i++) begin
            d[8*i +: 8] = pattern(a + i);
        end
        return d;
    endfunction

    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic take_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        return b;
    endfunction

    task automatic report_failure(inout int count, input string msg);
        count++;
        $display("FAILED at %0t: %s", $time, msg);
    endtask

    task automatic offer_desc(input int idx);
        desc_addr <= axi_bus_pkg::addr_t'(ADDR_LIST[idx]);
        desc_len <= axi_bus_pkg::len_t'(LEN_LIST[idx]);
        desc_valid <= 1'b1;
        @(posedge aclk);
        while (!desc_ready) begin
            @(posedge aclk);
        end
    endtask

    // AXI slave, random ready and valid gaps only while stall_en is set
    always @(posedge aclk) begin
        if (!aresetn) begin
            lfsr = 16'd20561;
            r_beat = 0;
            mem_addr_q.delete();
            mem_len_q.delete();
            arready <= 1'b0;
            tready <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            arready <= stall_en ? (take_bit() | take_bit()) : 1'b1;
            tready <= stall_en ? (take_bit() | take_bit()) : 1'b1;
            if (arvalid && arready) begin
                mem_addr_q.push_back(int'(araddr));
                mem_len_q.push_back(int'(arlen));
            end
            if (!rvalid || rready) begin
                if (mem_addr_q.size() != 0 && (!stall_en || take_bit())) begin
                    rvalid <= 1'b1;
                    rdata <= beat_at((mem_addr_q[0] & ~(BPB - 1)) + BPB * r_beat);
                    if (r_beat == mem_len_q[0]) begin
                        r_beat = 0;
                        void'(mem_addr_q.pop_front());
                        void'(mem_len_q.pop_front());
                    end else begin
                        r_beat++;
                    end
                end else begin
                    rvalid <= 1'b0;
                end
            end
        end
    end

    // AR rules, burst limits and exact byte coverage per descriptor
    always @(posedge aclk) begin
        int span_end;
        if (!aresetn) begin
            ar_wait = 1'b0;
        end else begin
            if (desc_valid && desc_ready) begin
                ar_start_q.push_back(int'(desc_addr));
                ar_end_q.push_back(int'(desc_addr) + int'(desc_len));
            end
            if (ar_wait) begin
                assert (arvalid && araddr == ar_addr_d && arlen == ar_len_d)
                else report_failure(ar_errors, "AR changed while arready was low");
            end
            ar_wait = arvalid && !arready;
            ar_addr_d = araddr;
            ar_len_d = arlen;
            if (arvalid && arready) begin
                span_end = (int'(araddr) & ~(BPB - 1)) + (int'(arlen) + 1) * BPB;
                assert (int'(arlen) < `DMA_MAX_BURST_LEN)
                else report_failure(ar_errors, $sformatf("arlen %0d too long", arlen));
                assert (int'(araddr) / `DMA_PAGE_BYTES == (span_end - 1) / `DMA_PAGE_BYTES)
                else report_failure(ar_errors, $sformatf("burst at %h crosses a page", araddr));
                if (ar_start_q.size() == 0) begin
                    report_failure(ar_errors, "AR issued with no descriptor pending");
                end else begin
                    assert (int'(araddr) == ar_start_q[0])
                    else report_failure(ar_errors,
                        $sformatf("araddr %h, expected %h", araddr, ar_start_q[0]));
                    if (span_end >= ar_end_q[0]) begin
                        assert (span_end - ar_end_q[0] < BPB)
                        else report_failure(ar_errors, "burst reads past the descriptor");
                        void'(ar_start_q.pop_front());
                        void'(ar_end_q.pop_front());
                    end else begin
                        ar_start_q[0] = span_end;
                    end
                end
            end
        end
    end

    // scoreboard for the stream, descriptor intake and status pulse
    always @(posedge aclk) begin
        int remain;
        axi_bus_pkg::keep_t want_keep;
        logic want_last;
        logic [7:0] want_byte;
        if (!aresetn) begin
            hold = 1'b0;
            acc_d = 1'b0;
        end else begin
            if (desc_valid && desc_ready) begin
                accepted++;
                for (int i = 0; i < int'(desc_len); i++) begin
                    exp_q.push_back(pattern(int'(desc_addr) + i));
                end
                len_q.push_back(int'(desc_len));
            end
            if (acc_d) begin
                assert (!desc_ready)
                else report_failure(out_errors, "desc_ready high while a descriptor is split");
            end
            acc_d = desc_valid && desc_ready;

            // the final beat has just been written, so the output register is full
            if (status_valid) begin
                assert (tvalid)
                else report_failure(out_errors, "status_valid with an empty output register");
                status_count++;
            end

            if (hold) begin
                assert (tvalid && tdata == hold_data && tkeep == hold_keep && tlast == hold_last)
                else report_failure(out_errors, "stream beat changed while tready was low");
            end
            hold = tvalid && !tready;
            hold_data = tdata;
            hold_keep = tkeep;
            hold_last = tlast;

            if (tvalid && tready) begin
                beats++;
                if (len_q.size() == 0) begin
                    report_failure(out_errors, "stream beat with no descriptor pending");
                end else begin
                    remain = len_q[0] - done_bytes;
                    want_last = (remain <= BPB);
                    want_keep = want_last ? axi_bus_pkg::keep_t'((1 << remain) - 1) : '1;
                    assert (tkeep == want_keep && tlast == want_last)
                    else report_failure(out_errors, $sformatf("tkeep %b tlast %b, expected %b %b",
                        tkeep, tlast, want_keep, want_last));
                    for (int i = 0; i < BPB; i++) begin
                        if (tkeep[i]) begin
                            want_byte = (exp_q.size() != 0) ? exp_q.pop_front() : 8'h00;
                            assert (tdata[8*i +: 8] == want_byte)
                            else report_failure(out_errors, $sformatf(
                                "lane %0d byte %h, expected %h", i, tdata[8*i +: 8], want_byte));
                        end
                    end
                    if (want_last) begin
                        void'(len_q.pop_front());
                        done_bytes = 0;
                        last_count++;
                        assert (status_count >= last_count)
                        else report_failure(out_errors, "tlast beat left before its status pulse");
                    end else begin
                        done_bytes += BPB;
                    end
                end
            end

            // the skid holds at most two final beats that still wait for tready
            if (status_valid) begin
                assert (status_count - last_count <= 2)
                else report_failure(out_errors, "status_valid with no final beat in the skid");
            end
        end
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the stream did not drain", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        int total_bytes;
        int end_errors;
        int total_errors;
        total_bytes = 0;
        end_errors = 0;
        for (int i = 0; i < NUM_DESC; i++) begin
            total_bytes += LEN_LIST[i];
        end
        cycle_limit = 40 * total_bytes + 2000;

        repeat (16) @(posedge aclk);
        aresetn <= 1'b1;
        repeat (2) begin
            @(posedge aclk);
            assert (!arvalid && !rready && !tvalid && !status_valid && desc_ready)
            else report_failure(end_errors, "outputs not idle after reset");
        end

        for (int i = 0; i < STALL_FROM; i++) begin
            offer_desc(i);
        end
        desc_valid <= 1'b0;
        while (status_count < STALL_FROM || exp_q.size() != 0) begin
            @(posedge aclk);
        end

        stall_en <= 1'b1;
        for (int i = STALL_FROM; i < NUM_DESC; i++) begin
            offer_desc(i);
        end
        desc_valid <= 1'b0;
        while (status_count < NUM_DESC || exp_q.size() != 0) begin
            @(posedge aclk);
        end
        // room for any stray beat or pulse to show up
        repeat (40) @(posedge aclk);

        assert (accepted == NUM_DESC && status_count == NUM_DESC && last_count == NUM_DESC)
        else report_failure(end_errors, $sformatf("%0d accepted, %0d status, %0d tlast",
            accepted, status_count, last_count));
        assert (len_q.size() == 0 && ar_start_q.size() == 0 && mem_addr_q.size() == 0)
        else report_failure(end_errors, "transfers left over at the end");

        total_errors = out_errors + ar_errors + end_errors;
        $display("%0d descriptors, %0d stream beats, %0d status pulses, %0d errors",
            accepted, beats, status_count, total_errors);
        if (total_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/axi_dma_rd.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_settings.svh"

// read DMA, descriptors in, AXI read bursts out, aligned byte stream back
module axi_dma_rd (
    input  wire                     aclk,
    input  wire                     aresetn,
    input  wire axi_bus_pkg::addr_t desc_addr,
    input  wire axi_bus_pkg::len_t  desc_len,
    input  wire                     desc_valid,
    output logic                    desc_ready,
    output axi_bus_pkg::addr_t      araddr,
    output axi_bus_pkg::arlen_t     arlen,
    output logic                    arvalid,
    input  wire                     arready,
    input  wire axi_bus_pkg::data_t rdata,
    input  wire                     rvalid,
    output logic                    rready,
    output axi_bus_pkg::data_t      tdata,
    output axi_bus_pkg::keep_t      tkeep,
    output logic                    tlast,
    output logic                    tvalid,
    input  wire                     tready,
    output logic                    status_valid
);

    dma_cmd_pkg::rd_cmd_t cmd_wr_data;
    dma_cmd_pkg::rd_cmd_t cmd_rd_data;
    logic cmd_wr_valid;
    logic cmd_wr_ready;
    logic cmd_rd_valid;
    logic cmd_rd_ready;
    axi_bus_pkg::data_t out_data;
    axi_bus_pkg::keep_t out_keep;
    logic out_last;
    logic out_valid;
    logic in_ready;
    logic in_ready_early;

    dma_rd_burst_gen u_burst_gen (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .desc_addr    (desc_addr),
        .desc_len     (desc_len),
        .desc_valid   (desc_valid),
        .desc_ready   (desc_ready),
        .araddr       (araddr),
        .arlen        (arlen),
        .arvalid      (arvalid),
        .arready      (arready),
        .cmd_wr_data  (cmd_wr_data),
        .cmd_wr_valid (cmd_wr_valid),
        .cmd_wr_ready (cmd_wr_ready)
    );

    // lets the request side run ahead by up to the queue depth
    cmd_queue #(
        .item_t (dma_cmd_pkg::rd_cmd_t),
        .DEPTH  (`DMA_QUEUE_DEPTH)
    ) u_cmd_queue (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .wr_data  (cmd_wr_data),
        .wr_valid (cmd_wr_valid),
        .wr_ready (cmd_wr_ready),
        .rd_data  (cmd_rd_data),
        .rd_valid (cmd_rd_valid),
        .rd_ready (cmd_rd_ready)
    );

    dma_rd_align u_align (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .cmd_rd_data    (cmd_rd_data),
        .cmd_rd_valid   (cmd_rd_valid),
        .cmd_rd_ready   (cmd_rd_ready),
        .rdata          (rdata),
        .rvalid         (rvalid),
        .rready         (rready),
        .out_data       (out_data),
        .out_keep       (out_keep),
        .out_last       (out_last),
        .out_valid      (out_valid),
        .in_ready       (in_ready),
        .in_ready_early (in_ready_early),
        .status_valid   (status_valid)
    );

    axis_skid_reg u_skid (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .in_data        (out_data),
        .in_keep        (out_keep),
        .in_last        (out_last),
        .in_valid       (out_valid),
        .in_ready       (in_ready),
        .in_ready_early (in_ready_early),
        .tdata          (tdata),
        .tkeep          (tkeep),
        .tlast          (tlast),
        .tvalid         (tvalid),
        .tready         (tready)
    );

endmodule

`default_nettype wire

/* src/axis_skid_reg.sv */
`timescale 1ns/1ps
`default_nettype none

// stream output register with one extra slot to cover registered ready
module axis_skid_reg (
    input  wire                     aclk,
    input  wire                     aresetn,
    input  wire axi_bus_pkg::data_t in_data,
    input  wire axi_bus_pkg::keep_t in_keep,
    input  wire                     in_last,
    input  wire                     in_valid,
    output logic                    in_ready,
    output logic                    in_ready_early,
    output axi_bus_pkg::data_t      tdata,
    output axi_bus_pkg::keep_t      tkeep,
    output logic                    tlast,
    output logic                    tvalid,
    input  wire                     tready
);

    axi_bus_pkg::data_t tmp_data;
    axi_bus_pkg::keep_t tmp_keep;
    logic tmp_last;
    logic tmp_valid;
    logic to_out;
    logic to_tmp;
    logic tmp_to_out;

    // ready next cycle unless the temp slot could end up needed twice
    assign in_ready_early = tready || (!tmp_valid && (!tvalid || !in_valid));

    always_comb begin
        to_out = 1'b0;
        to_tmp = 1'b0;
        tmp_to_out = 1'b0;
        if (in_ready) begin
            if (tready || !tvalid) begin
                to_out = 1'b1;
            end else begin
                to_tmp = 1'b1;
            end
        end else if (tready) begin
            tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            in_ready <= 1'b0;
            tvalid <= 1'b0;
            tmp_valid <= 1'b0;
        end else begin
            in_ready <= in_ready_early;
            if (to_out) begin
                tvalid <= in_valid;
            end else if (tmp_to_out) begin
                tvalid <= tmp_valid;
            end
            if (to_tmp) begin
                tmp_valid <= in_valid;
            end else if (tmp_to_out) begin
                tmp_valid <= 1'b0;
            end
        end

        if (to_out) begin
            tdata <= in_data;
            tkeep <= in_keep;
            tlast <= in_last;
        end else if (tmp_to_out) begin
            tdata <= tmp_data;
            tkeep <= tmp_keep;
            tlast <= tmp_last;
        end
        if (to_tmp) begin
            tmp_data <= in_data;
            tmp_keep <= in_keep;
            tmp_last <= in_last;
        end
    end

endmodule

`default_nettype wire

/* src/dma_rd_align.sv */
`timescale 1ns/1ps
`default_nettype none

// data side, realigns R beats to lane 0 and marks the end of each descriptor
module dma_rd_align (
    input  wire                       aclk,
    input  wire                       aresetn,
    input  wire dma_cmd_pkg::rd_cmd_t cmd_rd_data,
    input  wire                       cmd_rd_valid,
    output logic                      cmd_rd_ready,
    input  wire axi_bus_pkg::data_t   rdata,
    input  wire                       rvalid,
    output logic                      rready,
    output axi_bus_pkg::data_t        out_data,
    output axi_bus_pkg::keep_t        out_keep,
    output logic                      out_last,
    output logic                      out_valid,
    input  wire                       in_ready,
    input  wire                       in_ready_early,
    output logic                      status_valid
);

    localparam int BYTES = axi_bus_pkg::BYTES_PER_BEAT;

    typedef enum logic {idle, read} state_t;

    state_t state;
    dma_cmd_pkg::offset_t offset_reg;
    dma_cmd_pkg::offset_t last_off_reg;
    dma_cmd_pkg::cycle_count_t in_count;
    dma_cmd_pkg::cycle_count_t out_count;
    logic in_active;
    logic in_active_next;
    logic bubble_reg;
    logic out_last_reg;
    axi_bus_pkg::data_t save_reg;
    logic [2*$bits(axi_bus_pkg::data_t)-1:0] pair;
    logic r_fire;
    logic step;
    logic finish;

    assign cmd_rd_ready = (state == idle);
    assign r_fire = rready && rvalid;

    // one step per R beat, or per cycle once all R beats are in
    assign step = (state == read) && in_ready && (r_fire || !in_active);
    assign out_valid = step && !bubble_reg;
    assign out_last = out_last_reg;
    assign finish = out_valid && out_last_reg;
    assign in_active_next = (step && in_active) ? (in_count != '0) : in_active;

    // the saved beat supplies the low bytes, the new beat the high bytes
    assign pair = {rdata, save_reg};
    assign out_data = axi_bus_pkg::data_t'(pair >> ((BYTES - offset_reg) * 8));

    always_comb begin
        out_keep = '1;
        if (out_last_reg && last_off_reg != '0) begin
            out_keep = axi_bus_pkg::keep_t'('1) >> (BYTES - last_off_reg);
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= idle;
            rready <= 1'b0;
            status_valid <= 1'b0;
            in_active <= 1'b0;
        end else begin
            status_valid <= finish;
            case (state)
                idle: begin
                    rready <= cmd_rd_valid && in_ready_early;
                    if (cmd_rd_valid) begin
                        state <= read;
                        in_active <= 1'b1;
                    end
                end
                read: begin
                    rready <= in_ready_early && in_active_next && !finish;
                    in_active <= in_active_next;
                    if (finish) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end

        if (cmd_rd_valid && cmd_rd_ready) begin
            offset_reg <= cmd_rd_data.offset;
            last_off_reg <= cmd_rd_data.last_cycle_offset;
            bubble_reg <= cmd_rd_data.bubble_cycle;
            in_count <= cmd_rd_data.input_cycle_count;
            out_count <= cmd_rd_data.output_cycle_count;
            out_last_reg <= (cmd_rd_data.output_cycle_count == '0);
        end else if (step) begin
            bubble_reg <= 1'b0;
            if (in_active) begin
                in_count <= in_count - 1'b1;
            end
            if (!bubble_reg) begin
                out_count <= out_count - 1'b1;
                out_last_reg <= (out_count == dma_cmd_pkg::cycle_count_t'(1));
            end
        end

        if (step && r_fire) begin
            save_reg <= rdata;
        end
    end

endmodule

`default_nettype wire

/* src/dma_rd_burst_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dma_settings.svh"

// accepts descriptors and splits each one into AXI read bursts
module dma_rd_burst_gen (
    input  wire                      aclk,
    input  wire                      aresetn,
    input  wire axi_bus_pkg::addr_t  desc_addr,
    input  wire axi_bus_pkg::len_t   desc_len,
    input  wire                      desc_valid,
    output logic                     desc_ready,
    output axi_bus_pkg::addr_t       araddr,
    output axi_bus_pkg::arlen_t      arlen,
    output logic                     arvalid,
    input  wire                      arready,
    output dma_cmd_pkg::rd_cmd_t     cmd_wr_data,
    output logic                     cmd_wr_valid,
    input  wire                      cmd_wr_ready
);

    localparam int SHIFT = axi_bus_pkg::BEAT_SHIFT;
    localparam int PAGE_SHIFT = $clog2(`DMA_PAGE_BYTES);
    localparam axi_bus_pkg::len_t MAX_BURST_BYTES =
        axi_bus_pkg::len_t'(`DMA_MAX_BURST_LEN * axi_bus_pkg::BYTES_PER_BEAT);
    localparam axi_bus_pkg::len_t PAGE_BYTES = axi_bus_pkg::len_t'(`DMA_PAGE_BYTES);

    typedef enum logic {idle, start} state_t;

    state_t state;
    axi_bus_pkg::addr_t addr_reg;
    axi_bus_pkg::len_t remain_reg;
    axi_bus_pkg::len_t lane_len;
    axi_bus_pkg::len_t page_room;
    axi_bus_pkg::len_t burst_bytes;
    logic [SHIFT-1:0] desc_lane;
    logic [`DMA_LEN_WIDTH:0] in_span;
    logic issue;

    assign desc_lane = desc_addr[SHIFT-1:0];
    assign desc_ready = (state == idle) && cmd_wr_ready;
    assign cmd_wr_valid = desc_valid && desc_ready;
    // the next burst is only worked out once the previous AR is gone
    assign issue = (state == start) && !arvalid;

    // beats the data side will see, counted from the lane of the start address
    assign in_span = {1'b0, desc_len} + (`DMA_LEN_WIDTH + 1)'(desc_lane) - 1'b1;

    always_comb begin
        cmd_wr_data.offset =
            dma_cmd_pkg::offset_t'(axi_bus_pkg::BYTES_PER_BEAT - desc_lane);
        cmd_wr_data.last_cycle_offset = desc_len[SHIFT-1:0];
        cmd_wr_data.bubble_cycle = (desc_lane != '0);
        cmd_wr_data.input_cycle_count = dma_cmd_pkg::cycle_count_t'(in_span >> SHIFT);
        cmd_wr_data.output_cycle_count =
            dma_cmd_pkg::cycle_count_t'((desc_len - 1'b1) >> SHIFT);
    end

    // burst size: remaining bytes, capped by max burst and by the page end
    assign lane_len = axi_bus_pkg::len_t'(addr_reg[SHIFT-1:0]);
    assign page_room = PAGE_BYTES - axi_bus_pkg::len_t'(addr_reg[PAGE_SHIFT-1:0]);

    always_comb begin
        if (remain_reg <= MAX_BURST_BYTES - lane_len) begin
            burst_bytes = remain_reg;
        end else begin
            burst_bytes = MAX_BURST_BYTES - lane_len;
        end
        if (burst_bytes > page_room) begin
            burst_bytes = page_room;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= idle;
            arvalid <= 1'b0;
        end else begin
            if (issue) begin
                arvalid <= 1'b1;
            end else if (arready) begin
                arvalid <= 1'b0;
            end
            case (state)
                idle: begin
                    if (cmd_wr_valid) begin
                        state <= start;
                    end
                end
                start: begin
                    if (issue && remain_reg == burst_bytes) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end

        if (cmd_wr_valid) begin
            addr_reg <= desc_addr;
            remain_reg <= desc_len;
        end else if (issue) begin
            addr_reg <= addr_reg + axi_bus_pkg::addr_t'(burst_bytes);
            remain_reg <= remain_reg - burst_bytes;
        end

        if (issue) begin
            araddr <= addr_reg;
            arlen <= axi_bus_pkg::arlen_t'((burst_bytes + lane_len - 1'b1) >> SHIFT);
        end
    end

endmodule

`default_nettype wire

/* src/cmd_queue.sv */
`timescale 1ns/1ps
`default_nettype none

// small FIFO, head item is visible on rd_data while rd_valid is high
module cmd_queue #(
    parameter type item_t = logic,
    parameter int DEPTH = 4
) (
    input  wire        aclk,
    input  wire        aresetn,
    input  wire item_t wr_data,
    input  wire        wr_valid,
    output logic       wr_ready,
    output item_t      rd_data,
    output logic       rd_valid,
    input  wire        rd_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    item_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] count;
    logic push;
    logic pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign wr_ready = (count != (PTR_W + 1)'(DEPTH));
    assign rd_valid = (count != '0);
    assign rd_data = mem[rd_ptr];
    assign push = wr_valid && wr_ready;
    assign pop = rd_valid && rd_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // simultaneous push and pop leaves the fill level alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* src/dma_cmd_pkg.sv */
`default_nettype none

`include "dma_settings.svh"

// per-descriptor command handed from the request side to the data side
package dma_cmd_pkg;

    // byte lane inside one beat
    typedef logic [axi_bus_pkg::BEAT_SHIFT-1:0] offset_t;

    // beat counter, one spare bit above the longest transfer
    typedef logic [`DMA_LEN_WIDTH-axi_bus_pkg::BEAT_SHIFT:0] cycle_count_t;

    typedef struct packed {
        // shift applied to the joined pair of R beats
        offset_t offset;
        // valid bytes in the final stream beat, 0 means all
        offset_t last_cycle_offset;
        // first R beat is only saved, no stream beat comes out
        logic bubble_cycle;
        // R beats minus one
        cycle_count_t input_cycle_count;
        // stream beats minus one
        cycle_count_t output_cycle_count;
    } rd_cmd_t;

endpackage

`default_nettype wire

/* src/axi_bus_pkg.sv */
`default_nettype none

`include "dma_settings.svh"

// word types of the AXI read channels and the output stream
package axi_bus_pkg;

    localparam int BYTES_PER_BEAT = `DMA_DATA_WIDTH / 8;
    // log2 of bytes per beat, turns byte counts into beat counts
    localparam int BEAT_SHIFT = $clog2(BYTES_PER_BEAT);

    typedef logic [`DMA_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`DMA_DATA_WIDTH-1:0] data_t;
    typedef logic [BYTES_PER_BEAT-1:0] keep_t;
    // AXI4 burst length, beats minus one
    typedef logic [7:0] arlen_t;
    typedef logic [`DMA_LEN_WIDTH-1:0] len_t;

endpackage

`default_nettype wire

/* src/dma_settings.svh */
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// AXI address width in bits
`define DMA_ADDR_WIDTH 16
// AXI read data and stream data width in bits
`define DMA_DATA_WIDTH 32
// width of the descriptor byte length
`define DMA_LEN_WIDTH 20
// largest burst in beats
`define DMA_MAX_BURST_LEN 16
// outstanding descriptors between request and data side
`define DMA_QUEUE_DEPTH 4
// no burst may cross this boundary
`define DMA_PAGE_BYTES 4096

`endif
